/* hw/mul_pkg.sv */
// shared widths and types for the two-lane multiply unit
// products are truncated to the low WORD_BITS, signedness is not tracked
// WORD_BITS must be a whole multiple of DIGIT_BITS

`default_nettype none

package mul_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int WORD_BITS  = 64;  // operand and product width
  localparam int DIGIT_BITS = 16;  // multiplier bits retired per stage
  localparam int AR_BITS    = 5;   // architectural register index
  localparam int PR_BITS    = 7;   // physical register index

  //////////////////////////////////////////////////////////////////////
  // pipeline shape
  //////////////////////////////////////////////////////////////////////

  // one stage per multiplier digit
  localparam int NUM_STAGES = WORD_BITS / DIGIT_BITS;
  localparam int NUM_LANES  = 2;  // issue lanes from the reservation station

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  // operands, partial sums and products
  typedef logic [WORD_BITS-1:0] word_t;

  typedef logic [AR_BITS-1:0] ar_idx_t;  // destination arch reg
  typedef logic [PR_BITS-1:0] pr_idx_t;  // destination phys reg

endpackage

`default_nettype wire

/* hw/mul_if.sv */
// bundles used inside one multiply lane
// no clock in either bundle, every field is sampled by the receiving stage
// valid is a single-cycle strobe, payload fields are don't-care without it

`timescale 1ns/10ps
`default_nettype none

// one hop between multiplier stages
interface mult_hop_if;
  import mul_pkg::*;

  logic    valid;
  word_t   product;  // running partial sum
  word_t   mplier;   // multiplier, consumed one digit per hop
  word_t   mcand;    // multiplicand, shifted up one digit per hop
  ar_idx_t dest_ar;
  pr_idx_t dest_pr;

  modport src (
    output valid,
    output product,
    output mplier,
    output mcand,
    output dest_ar,
    output dest_pr
  );

  modport dst (
    input valid,
    input product,
    input mplier,
    input mcand,
    input dest_ar,
    input dest_pr
  );

endinterface

// captured operation handed from a lane into its pipe
interface mul_issue_if;
  import mul_pkg::*;

  logic    valid;
  word_t   opa;
  word_t   opb;
  ar_idx_t dest_ar;
  pr_idx_t dest_pr;

  modport src (output valid, output opa, output opb, output dest_ar, output dest_pr);
  modport dst (input valid, input opa, input opb, input dest_ar, input dest_pr);

endinterface

`default_nettype wire

/* hw/mult_stage.sv */
// one radix-2^DIGIT_BITS stage of the multiply pipeline, 1 cycle
// outgoing product is the sum of two registers, so the adder sits after the flops
// only valid is reset, payload and tags are don't-care when valid is low

`timescale 1ns/10ps
`default_nettype none

module mult_stage (
  input  logic    clock,
  input  logic    reset,
  mult_hop_if.dst hop_in,
  mult_hop_if.src hop_out
);

  import mul_pkg::*;

  word_t digit;             // low multiplier digit, zero extended
  word_t partial_product;
  word_t next_mplier;
  word_t next_mcand;
  word_t prod_in_reg;       // partial sum carried in
  word_t partial_prod_reg;  // this stage's contribution

  //////////////////////////////////////////////////////////////////////
  // digit product and operand shifts
  //////////////////////////////////////////////////////////////////////

  assign digit = {{(WORD_BITS-DIGIT_BITS){1'b0}}, hop_in.mplier[DIGIT_BITS-1:0]};

  // low WORD_BITS only, upper bits fall off
  assign partial_product = digit * hop_in.mcand;

  assign next_mplier = hop_in.mplier >> DIGIT_BITS;  // drop the used digit
  assign next_mcand  = hop_in.mcand << DIGIT_BITS;   // weight of next digit

  //////////////////////////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    prod_in_reg      <= hop_in.product;
    partial_prod_reg <= partial_product;
    hop_out.mplier   <= next_mplier;
    hop_out.mcand    <= next_mcand;
    hop_out.dest_ar  <= hop_in.dest_ar;  // tags ride with their data
    hop_out.dest_pr  <= hop_in.dest_pr;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      hop_out.valid <= 1'b0;
    end
    else
    begin
      hop_out.valid <= hop_in.valid;
    end
  end

  // accumulate after the registers
  assign hop_out.product = prod_in_reg + partial_prod_reg;

endmodule

`default_nettype wire

/* hw/mult_pipe.sv */
// NUM_STAGES-deep multiply pipe, fixed latency of NUM_STAGES cycles
// accepts a new operation every cycle, no stall and no back-pressure
// result holds the low WORD_BITS of opa * opb with the issued tags

`timescale 1ns/10ps
`default_nettype none

module mult_pipe (
  input  logic     clock,
  input  logic     reset,
  mul_issue_if.dst issue,
  mult_hop_if.src  result
);

  import mul_pkg::*;

  // hop[0] is the seed, hop[NUM_STAGES] is the finished product
  mult_hop_if hop [NUM_STAGES+1] ();

  //////////////////////////////////////////////////////////////////////
  // seed hop
  //////////////////////////////////////////////////////////////////////

  assign hop[0].valid   = issue.valid;
  assign hop[0].product = '0;  // nothing accumulated yet
  assign hop[0].mplier  = issue.opa;
  assign hop[0].mcand   = issue.opb;
  assign hop[0].dest_ar = issue.dest_ar;
  assign hop[0].dest_pr = issue.dest_pr;

  //////////////////////////////////////////////////////////////////////
  // stage chain
  //////////////////////////////////////////////////////////////////////

  // stage i retires multiplier digit i
  for (genvar i = 0; i < NUM_STAGES; i++)
  begin : g_stage
    mult_stage u_stage (
      .clock   (clock),
      .reset   (reset),
      .hop_in  (hop[i]),
      .hop_out (hop[i+1])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // last hop out
  //////////////////////////////////////////////////////////////////////

  assign result.valid   = hop[NUM_STAGES].valid;
  assign result.product = hop[NUM_STAGES].product;
  // residual operands, both zero after the last digit
  assign result.mplier  = hop[NUM_STAGES].mplier;
  assign result.mcand   = hop[NUM_STAGES].mcand;
  assign result.dest_ar = hop[NUM_STAGES].dest_ar;
  assign result.dest_pr = hop[NUM_STAGES].dest_pr;

endmodule

`default_nettype wire

/* hw/mul_lane.sv */
// one issue lane: register-read capture stage plus one multiply pipe
// latency from input sample to completion is 1 + NUM_STAGES cycles
// every multiply writes its destination, so write_enable follows complete

`timescale 1ns/10ps
`default_nettype none

module mul_lane (
  input  logic             clock,
  input  logic             reset,
  // from reservation station and register file
  input  logic             valid,
  input  mul_pkg::word_t   opa,
  input  mul_pkg::word_t   opb,
  input  mul_pkg::ar_idx_t dest_ar,
  input  mul_pkg::pr_idx_t dest_pr,
  // to completion bus and register file
  output logic             complete,
  output logic             write_enable,
  output mul_pkg::word_t   result,
  output mul_pkg::ar_idx_t cdb_dest_ar,
  output mul_pkg::pr_idx_t cdb_dest_pr
);

  import mul_pkg::*;

  mul_issue_if issue ();  // capture registers live here
  mult_hop_if  done ();   // final hop from the pipe

  //////////////////////////////////////////////////////////////////////
  // capture stage
  //////////////////////////////////////////////////////////////////////

  // operands and tags load every cycle, qualified only by valid
  always_ff @(posedge clock)
  begin
    issue.opa     <= opa;
    issue.opb     <= opb;
    issue.dest_ar <= dest_ar;
    issue.dest_pr <= dest_pr;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      issue.valid <= 1'b0;
    end
    else
    begin
      issue.valid <= valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // multiply pipe
  //////////////////////////////////////////////////////////////////////

  mult_pipe u_pipe (
    .clock  (clock),
    .reset  (reset),
    .issue  (issue),
    .result (done)
  );

  //////////////////////////////////////////////////////////////////////
  // completion outputs
  //////////////////////////////////////////////////////////////////////

  assign complete     = done.valid;  // one pulse per issued op
  assign write_enable = done.valid;
  assign result       = done.product;

  // tags came down the pipe with this product
  assign cdb_dest_ar = done.dest_ar;
  assign cdb_dest_pr = done.dest_pr;

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
// two-lane multiply functional unit, register operands only
// fixed latency of 5 cycles per lane, lanes run independently
// no back-pressure: an op can issue on every lane every cycle

`timescale 1ns/10ps
`default_nettype none

module mul_unit (
  input  logic             clock,
  input  logic             reset,

  // lane 0 issue
  input  logic             rs_valid_inst0,
  input  mul_pkg::word_t   prf_pra0,         // register A value
  input  mul_pkg::word_t   prf_prb0,         // register B value
  input  mul_pkg::ar_idx_t rs_dest_ar_idx0,
  input  mul_pkg::pr_idx_t rs_dest_pr_idx0,

  // lane 1 issue
  input  logic             rs_valid_inst1,
  input  mul_pkg::word_t   prf_pra1,
  input  mul_pkg::word_t   prf_prb1,
  input  mul_pkg::ar_idx_t rs_dest_ar_idx1,
  input  mul_pkg::pr_idx_t rs_dest_pr_idx1,

  // lane 0 completion
  output logic             cdb_complete0,
  output mul_pkg::ar_idx_t cdb_dest_ar_idx0,
  output mul_pkg::pr_idx_t cdb_prf_dest_pr_idx0,
  output mul_pkg::word_t   prf_result0,
  output logic             prf_write_enable0,

  // lane 1 completion
  output logic             cdb_complete1,
  output mul_pkg::ar_idx_t cdb_dest_ar_idx1,
  output mul_pkg::pr_idx_t cdb_prf_dest_pr_idx1,
  output mul_pkg::word_t   prf_result1,
  output logic             prf_write_enable1
);

  //////////////////////////////////////////////////////////////////////
  // lane 0
  //////////////////////////////////////////////////////////////////////

  mul_lane u_lane0 (
    .clock        (clock),
    .reset        (reset),
    .valid        (rs_valid_inst0),
    .opa          (prf_pra0),
    .opb          (prf_prb0),
    .dest_ar      (rs_dest_ar_idx0),
    .dest_pr      (rs_dest_pr_idx0),
    .complete     (cdb_complete0),
    .write_enable (prf_write_enable0),
    .result       (prf_result0),
    .cdb_dest_ar  (cdb_dest_ar_idx0),
    .cdb_dest_pr  (cdb_prf_dest_pr_idx0)
  );

  //////////////////////////////////////////////////////////////////////
  // lane 1
  //////////////////////////////////////////////////////////////////////

  // same lane, separate pipe, no shared state with lane 0
  mul_lane u_lane1 (
    .clock        (clock),
    .reset        (reset),
    .valid        (rs_valid_inst1),
    .opa          (prf_pra1),
    .opb          (prf_prb1),
    .dest_ar      (rs_dest_ar_idx1),
    .dest_pr      (rs_dest_pr_idx1),
    .complete     (cdb_complete1),
    .write_enable (prf_write_enable1),
    .result       (prf_result1),
    .cdb_dest_ar  (cdb_dest_ar_idx1),
    .cdb_dest_pr  (cdb_prf_dest_pr_idx1)
  );

endmodule

`default_nettype wire

/* tests/tb_mul_unit.sv */
// directed testbench for the two-lane multiply unit
// expected products are the low 64 bits of the full 128-bit product
// latency counts from the edge that drives an issue to the edge that shows its result

`timescale 1ns/10ps
`default_nettype none

module tb_mul_unit;

  import mul_pkg::*;

  localparam int LATENCY     = 5;
  localparam int TEST_CYCLES = 400;              // rough length of all tests together
  localparam int CYCLE_LIMIT = 5 * TEST_CYCLES;  // 2000 cycles

  typedef struct packed {
    word_t       product;
    ar_idx_t     dest_ar;
    pr_idx_t     dest_pr;
    logic [31:0] stamp;    // cycle of the driving edge
  } expect_t;

  logic    clock;
  logic    reset;
  logic    drv_valid [NUM_LANES];  // DUT inputs, driven at the rising edge
  word_t   drv_a [NUM_LANES];
  word_t   drv_b [NUM_LANES];
  ar_idx_t drv_ar [NUM_LANES];
  pr_idx_t drv_pr [NUM_LANES];
  logic    nxt_valid [NUM_LANES];  // staged values for the next edge
  word_t   nxt_a [NUM_LANES];
  word_t   nxt_b [NUM_LANES];
  ar_idx_t nxt_ar [NUM_LANES];
  pr_idx_t nxt_pr [NUM_LANES];
  logic    out_complete [NUM_LANES];
  logic    out_we [NUM_LANES];
  word_t   out_result [NUM_LANES];
  ar_idx_t out_ar [NUM_LANES];
  pr_idx_t out_pr [NUM_LANES];

  expect_t     exp_q [NUM_LANES][$];  // scoreboard, one queue per lane
  int          err_count = 0;
  int          check_count = 0;
  int          cycle = 0;
  int          issue_count [NUM_LANES];
  int          done_count [NUM_LANES];
  logic        prev_reset = 1'b0;
  logic        armed = 1'b0;          // outputs are known once reset has been seen
  logic [63:0] rng = 64'd21177;

  mul_unit DUT (
    .clock (clock), .reset (reset),
    .rs_valid_inst0 (drv_valid[0]), .prf_pra0 (drv_a[0]), .prf_prb0 (drv_b[0]),
    .rs_dest_ar_idx0 (drv_ar[0]), .rs_dest_pr_idx0 (drv_pr[0]),
    .rs_valid_inst1 (drv_valid[1]), .prf_pra1 (drv_a[1]), .prf_prb1 (drv_b[1]),
    .rs_dest_ar_idx1 (drv_ar[1]), .rs_dest_pr_idx1 (drv_pr[1]),
    .cdb_complete0 (out_complete[0]), .cdb_dest_ar_idx0 (out_ar[0]),
    .cdb_prf_dest_pr_idx0 (out_pr[0]), .prf_result0 (out_result[0]),
    .prf_write_enable0 (out_we[0]),
    .cdb_complete1 (out_complete[1]), .cdb_dest_ar_idx1 (out_ar[1]),
    .cdb_prf_dest_pr_idx1 (out_pr[1]), .prf_result1 (out_result[1]),
    .prf_write_enable1 (out_we[1])
  );

  always #20 clock = ~clock;

  always @(posedge clock)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycle);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    rng = xorshift64(rng);
    return rng;
  endfunction

  function automatic word_t ref_product(input word_t a, input word_t b);
    logic [2*WORD_BITS-1:0] full;
    full = {{WORD_BITS{1'b0}}, a} * {{WORD_BITS{1'b0}}, b};
    return full[WORD_BITS-1:0];  // truncated like the unit
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERROR %0t %s got %h expected %h", $time, sig, got, exp);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    err_count++;
  endtask

  task automatic load_op(input int lane, input word_t a, input word_t b,
                         input ar_idx_t ar, input pr_idx_t pr);
    nxt_valid[lane] = 1'b1;
    nxt_a[lane]     = a;
    nxt_b[lane]     = b;
    nxt_ar[lane]    = ar;
    nxt_pr[lane]    = pr;
  endtask

  task automatic idle_lanes();
    nxt_valid[0] = 1'b0;
    nxt_valid[1] = 1'b0;
  endtask

  // apply the staged inputs at the next rising edge
  task automatic step();
    @(posedge clock);
    for (int i = 0; i < NUM_LANES; i++)
    begin
      drv_valid[i] <= nxt_valid[i];
      drv_a[i]     <= nxt_a[i];
      drv_b[i]     <= nxt_b[i];
      drv_ar[i]    <= nxt_ar[i];
      drv_pr[i]    <= nxt_pr[i];
    end
  endtask

  // wait until both lanes have returned every issued op
  task automatic drain();
    idle_lanes();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
    begin
      step();
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // scoreboard, sampled at the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic score_lane(input int lane);
    expect_t e;
    if (armed && out_we[lane] !== out_complete[lane])
      report_mismatch($sformatf("prf_write_enable%0d", lane), 64'(out_we[lane]),
                      64'(out_complete[lane]));
    if (prev_reset && out_complete[lane] !== 1'b0)
    begin
      report_failure($sformatf("lane %0d completed while reset was held", lane));
    end
    else if (out_complete[lane] === 1'b1)
    begin
      done_count[lane]++;
      check_count++;
      if (exp_q[lane].size() == 0)
      begin
        report_failure($sformatf("unexpected completion on lane %0d", lane));
      end
      else
      begin
        e = exp_q[lane].pop_front();
        if (out_result[lane] !== e.product)
          report_mismatch($sformatf("prf_result%0d", lane), out_result[lane], e.product);
        if (out_ar[lane] !== e.dest_ar)
          report_mismatch($sformatf("cdb_dest_ar_idx%0d", lane), 64'(out_ar[lane]),
                          64'(e.dest_ar));
        if (out_pr[lane] !== e.dest_pr)
          report_mismatch($sformatf("cdb_prf_dest_pr_idx%0d", lane), 64'(out_pr[lane]),
                          64'(e.dest_pr));
        if (cycle - int'(e.stamp) != LATENCY)
          report_failure($sformatf("lane %0d result came %0d cycles after issue, not %0d",
                                   lane, cycle - int'(e.stamp), LATENCY));
      end
    end
    if (reset)
    begin
      exp_q[lane].delete();  // in-flight ops are lost
    end
    else if (drv_valid[lane])
    begin
      e.product = ref_product(drv_a[lane], drv_b[lane]);
      e.dest_ar = drv_ar[lane];
      e.dest_pr = drv_pr[lane];
      e.stamp   = cycle;
      exp_q[lane].push_back(e);
      issue_count[lane]++;
    end
  endtask

  always @(negedge clock)
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      score_lane(i);
    end
    if (prev_reset)
      armed = 1'b1;
    prev_reset = reset;
  end

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_corner_products();
    word_t ca [6];
    word_t cb [6];
    int    errs;
    errs  = err_count;
    ca[0] = '0;
    cb[0] = 64'h1234_5678_9abc_def0;
    ca[1] = 64'd1;
    cb[1] = 64'hfedc_ba98_7654_3210;
    ca[2] = '1;
    cb[2] = '1;
    ca[3] = '1;
    cb[3] = 64'h0001_0001_0001_0001;  // carry per digit
    ca[4] = 64'h0000_0001_0000_0000;
    cb[4] = 64'h0000_0001_0000_0000;  // low half zero
    ca[5] = 64'h8000_ffff_8000_ffff;
    cb[5] = 64'h0000_ffff_ffff_ffff;
    for (int i = 0; i < 6; i++)
    begin
      load_op(0, ca[i], cb[i], ar_idx_t'(i), pr_idx_t'(i));
      load_op(1, cb[5-i], ca[5-i], ar_idx_t'(i + 8), pr_idx_t'(i + 64));  // swapped
      step();
    end
    drain();
    finish_test("corner_products", errs);
  endtask

  task automatic test_back_to_back();
    int errs;
    errs = err_count;
    for (int i = 0; i < 64; i++)
    begin
      load_op(0, rand64(), rand64(), ar_idx_t'(i), pr_idx_t'(i));
      load_op(1, rand64(), rand64(), ar_idx_t'(31 - (i % 32)), pr_idx_t'(i + 64));
      step();
    end
    drain();
    finish_test("back_to_back", errs);
  endtask

  task automatic test_tag_tracking();
    int          errs;
    logic [63:0] off;
    errs = err_count;
    off  = rand64();
    // odd strides give distinct tags over one lap of the index space
    for (int i = 0; i < 32; i++)
    begin
      load_op(0, rand64(), rand64(), ar_idx_t'((i * 13 + int'(off[4:0])) % 32),
              pr_idx_t'((i * 37 + int'(off[14:8])) % 128));
      load_op(1, rand64(), rand64(), ar_idx_t'((i * 7 + int'(off[20:16])) % 32),
              pr_idx_t'((i * 91 + int'(off[30:24])) % 128));
      step();
    end
    drain();
    finish_test("tag_tracking", errs);
  endtask

  task automatic test_bubbles();
    int          errs;
    int          issued [NUM_LANES];
    int          done [NUM_LANES];
    logic [63:0] r;
    errs = err_count;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      issued[l] = issue_count[l];
      done[l]   = done_count[l];
    end
    for (int i = 0; i < 80; i++)
    begin
      r = rand64();
      load_op(0, rand64(), rand64(), ar_idx_t'(r[12:8]), pr_idx_t'(r[22:16]));
      load_op(1, rand64(), rand64(), ar_idx_t'(r[28:24]), pr_idx_t'(r[38:32]));
      nxt_valid[0] = r[0];
      nxt_valid[1] = r[3] & r[5];  // sparser pattern on lane 1
      step();
    end
    drain();
    for (int l = 0; l < NUM_LANES; l++)
    begin
      check_count++;
      if (done_count[l] - done[l] != issue_count[l] - issued[l])
        report_failure($sformatf("lane %0d gave %0d completions for %0d issues", l,
                                 done_count[l] - done[l], issue_count[l] - issued[l]));
    end
    finish_test("bubbles", errs);
  endtask

  task automatic test_reset_busy();
    int errs;
    int done_before;
    errs = err_count;
    for (int i = 0; i < 6; i++)
    begin
      load_op(0, rand64(), rand64(), ar_idx_t'(i), pr_idx_t'(i));
      load_op(1, rand64(), rand64(), ar_idx_t'(i), pr_idx_t'(i));
      step();
    end
    idle_lanes();
    reset <= 1'b1;  // last op still sits in the capture stage
    repeat (4) step();
    reset <= 1'b0;
    step();
    done_before = done_count[0] + done_count[1];
    repeat (10) step();  // nothing may complete before new issues
    check_count++;
    if (done_count[0] + done_count[1] != done_before)
      report_failure("completions seen after reset with no new issues");
    for (int i = 0; i < 8; i++)
    begin
      load_op(0, rand64(), rand64(), ar_idx_t'(i + 20), pr_idx_t'(i + 100));
      load_op(1, rand64(), rand64(), ar_idx_t'(i + 10), pr_idx_t'(i + 50));
      step();
    end
    drain();
    finish_test("reset_busy", errs);
  endtask

  initial
  begin
    clock = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      drv_valid[i] = 1'b0;
      drv_a[i] = '0;
      drv_b[i] = '0;
      drv_ar[i] = '0;
      drv_pr[i] = '0;
      nxt_valid[i] = 1'b0;
      nxt_a[i] = '0;
      nxt_b[i] = '0;
      nxt_ar[i] = '0;
      nxt_pr[i] = '0;
      issue_count[i] = 0;
      done_count[i] = 0;
    end
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    test_corner_products();
    test_back_to_back();
    test_tag_tracking();
    test_bubbles();
    test_reset_busy();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/mul_pkg.sv
hw/mul_if.sv
hw/mult_stage.sv
hw/mult_pipe.sv
hw/mul_lane.sv
hw/mul_unit.sv
tests/tb_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiply unit testbench with Verilator
# exit status is nonzero unless the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f sim.f --top-module tb_mul_unit -Mdir obj_dir \
  && out="$(./obj_dir/Vtb_mul_unit)" \
  && echo "$out" \
  && echo "$out" | grep -qx "sim passed" \
  && echo "run OK" \
  || { echo "run FAILED"; exit 1; }
